//--- design/sq_pkg.sv
`default_nettype none

package sq_pkg;

    // ==========================================================
    // Widths and sizes
    // ==========================================================

    // Address and data width of the core
    localparam int XLEN = 32;

    // Queue depth when the top level keeps its default
    localparam int DEFAULT_SQ_DEPTH = 8;

    // Store access size
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_t;

    // Store data seen as one word or as four byte lanes
    // Lane 0 holds the least significant byte
    typedef union packed {
        logic [XLEN-1:0]  word;
        logic [3:0][7:0]  lanes;
    } data_word_t;

    // ==========================================================
    // Lane placement
    // ==========================================================

    // Moves raw store data into the lanes it occupies in memory
    function automatic data_word_t place_lanes(
        input mem_size_t  size,
        input logic [1:0] offset,
        input data_word_t data
    );
        data_word_t placed;
        placed.word = '0;
        case (size)
            BYTE: begin
                placed.lanes[offset] = data.lanes[0];
            end
            HALF: begin
                // Upper or lower lane pair by address bit 1
                placed.lanes[{offset[1], 1'b0}] = data.lanes[0];
                placed.lanes[{offset[1], 1'b1}] = data.lanes[1];
            end
            default: begin
                placed = data;
            end
        endcase
        return placed;
    endfunction

endpackage

`default_nettype wire

//--- design/sq_pointers.sv
`default_nettype none

module sq_pointers
    import sq_pkg::*;
#(
    parameter  int SQ_DEPTH = DEFAULT_SQ_DEPTH,
    localparam int IDX_W    = $clog2(SQ_DEPTH),
    localparam int CNT_W    = $clog2(SQ_DEPTH + 1)
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             dispatch_valid,
    input  logic             retire,
    input  logic             mispredict,
    input  logic             head_free,
    output logic             dispatch_ready,
    output logic             write_en,
    output logic             flush,
    output logic             committed_nonempty,
    output logic [IDX_W-1:0] head_idx,
    output logic [IDX_W-1:0] commit_idx,
    output logic [IDX_W-1:0] tail_idx,
    output logic [IDX_W-1:0] alloc_idx
);

    // Entries held between head and tail
    logic [CNT_W-1:0] occupancy;
    // Entries between head and commit that still wait to drain
    logic [CNT_W-1:0] committed_count;

    // Room for one more store
    assign dispatch_ready = occupancy < CNT_W'(SQ_DEPTH);
    assign write_en = dispatch_valid && dispatch_ready;
    assign flush = mispredict;
    // Needed because head equal to commit is either empty or all committed
    assign committed_nonempty = committed_count != '0;
    // Next store goes to the tail slot
    assign alloc_idx = tail_idx;

    // ==========================================================
    // Pointer and count update
    // ==========================================================
    always_ff @(posedge clock) begin
        if (!reset) begin
            head_idx        <= '0;
            commit_idx      <= '0;
            tail_idx        <= '0;
            occupancy       <= '0;
            committed_count <= '0;
        end else begin
            // Head moves only when the drain sees its ack
            head_idx <= head_idx + IDX_W'(head_free);
            if (flush) begin
                // Drop every uncommitted store
                // Committed ones stay and keep draining
                tail_idx        <= commit_idx;
                occupancy       <= committed_count - CNT_W'(head_free);
                committed_count <= committed_count - CNT_W'(head_free);
            end else begin
                tail_idx        <= tail_idx + IDX_W'(write_en);
                commit_idx      <= commit_idx + IDX_W'(retire);
                occupancy       <= occupancy + CNT_W'(write_en) - CNT_W'(head_free);
                committed_count <= committed_count + CNT_W'(retire) - CNT_W'(head_free);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/sq_entry_array.sv
`default_nettype none

module sq_entry_array
    import sq_pkg::*;
#(
    parameter  int SQ_DEPTH = DEFAULT_SQ_DEPTH,
    localparam int IDX_W    = $clog2(SQ_DEPTH)
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                write_en,
    input  mem_size_t           dispatch_size,
    input  logic [IDX_W-1:0]    tail_idx,
    input  logic                exec_valid,
    input  logic [IDX_W-1:0]    exec_idx,
    input  logic [XLEN-1:0]     exec_addr,
    input  logic [XLEN-1:0]     exec_data,
    input  logic                head_free,
    input  logic [IDX_W-1:0]    head_idx,
    input  logic                flush,
    input  logic [IDX_W-1:0]    commit_idx,
    input  logic                committed_nonempty,
    output logic [SQ_DEPTH-1:0] entry_valid,
    output logic [SQ_DEPTH-1:0] entry_executed,
    output logic [XLEN-1:0]     entry_addr [SQ_DEPTH],
    output data_word_t          entry_data [SQ_DEPTH],
    output mem_size_t           entry_size [SQ_DEPTH],
    output logic                head_valid,
    output logic                head_executed,
    output logic [XLEN-1:0]     head_addr,
    output data_word_t          head_data,
    output mem_size_t           head_size,
    output logic                unexecuted_store
);

    // Slots in the committed range from head up to commit
    logic [SQ_DEPTH-1:0] committed_mask;

    always_comb begin
        logic [IDX_W-1:0] span;
        logic [IDX_W-1:0] offset;
        span = commit_idx - head_idx;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            offset = IDX_W'(i) - head_idx;
            // A zero span with committed entries means the whole ring
            committed_mask[i] = committed_nonempty && (span == '0 || offset < span);
        end
    end

    // ==========================================================
    // Valid and executed bits
    // ==========================================================
    always_ff @(posedge clock) begin
        if (!reset) begin
            entry_valid    <= '0;
            entry_executed <= '0;
        end else begin
            // Address and data now known
            if (exec_valid) begin
                entry_executed[exec_idx] <= 1'b1;
            end
            // New store starts out unexecuted
            if (write_en) begin
                entry_valid[tail_idx]    <= 1'b1;
                entry_executed[tail_idx] <= 1'b0;
            end
            // Head written to the data cache
            if (head_free) begin
                entry_valid[head_idx]    <= 1'b0;
                entry_executed[head_idx] <= 1'b0;
            end
            // Last so that it wins over a dispatch in the same cycle
            if (flush) begin
                for (int i = 0; i < SQ_DEPTH; i++) begin
                    if (!committed_mask[i]) begin
                        entry_valid[i]    <= 1'b0;
                        entry_executed[i] <= 1'b0;
                    end
                end
            end
        end
    end

    // Payload fields
    always_ff @(posedge clock) begin
        if (write_en) begin
            entry_size[tail_idx] <= dispatch_size;
        end
        if (exec_valid) begin
            entry_addr[exec_idx]      <= exec_addr;
            entry_data[exec_idx].word <= exec_data;
        end
    end

    // Oldest entry for the drain
    assign head_valid    = entry_valid[head_idx];
    assign head_executed = entry_executed[head_idx];
    assign head_addr     = entry_addr[head_idx];
    assign head_data     = entry_data[head_idx];
    assign head_size     = entry_size[head_idx];

    // Some valid store still lacks its address or data
    assign unexecuted_store = |(entry_valid & ~entry_executed);

endmodule

`default_nettype wire

//--- design/sq_forward.sv
`default_nettype none

module sq_forward
    import sq_pkg::*;
#(
    parameter  int SQ_DEPTH = DEFAULT_SQ_DEPTH,
    localparam int IDX_W    = $clog2(SQ_DEPTH)
) (
    input  logic                load_valid,
    input  logic [XLEN-1:0]     load_addr,
    input  logic [IDX_W-1:0]    load_tail,
    input  logic [IDX_W-1:0]    head_idx,
    input  logic [SQ_DEPTH-1:0] entry_valid,
    input  logic [XLEN-1:0]     entry_addr [SQ_DEPTH],
    input  data_word_t          entry_data [SQ_DEPTH],
    input  mem_size_t           entry_size [SQ_DEPTH],
    output logic                forward_valid,
    output data_word_t          forward_data
);

    // Store covers the load byte
    function automatic logic covers(
        input mem_size_t       size,
        input logic [XLEN-1:0] store_addr,
        input logic [XLEN-1:0] addr
    );
        case (size)
            // Exact byte
            BYTE:    return store_addr == addr;
            // Same aligned half
            HALF:    return store_addr[XLEN-1:1] == addr[XLEN-1:1];
            // Same aligned word
            WORD:    return store_addr[XLEN-1:2] == addr[XLEN-1:2];
            default: return 1'b0;
        endcase
    endfunction

    // ==========================================================
    // Youngest older match
    // ==========================================================
    // Loads look up only while no store is unexecuted
    // so executed bits need no check here
    always_comb begin
        logic [IDX_W-1:0] span;
        logic [IDX_W-1:0] idx;
        logic             found;
        // Stores older than the load lie in head up to load_tail
        span = load_tail - head_idx;
        found = 1'b0;
        forward_data.word = '0;
        // Walk back from the slot just before load_tail
        for (int step = 0; step < SQ_DEPTH; step++) begin
            idx = load_tail - IDX_W'(step) - IDX_W'(1);
            if (load_valid && !found && IDX_W'(step) < span && entry_valid[idx]
                    && covers(entry_size[idx], entry_addr[idx], load_addr)) begin
                found = 1'b1;
                // Data as it would sit in memory
                forward_data = place_lanes(entry_size[idx], entry_addr[idx][1:0],
                                           entry_data[idx]);
            end
        end
        // Miss sends the load to the cache
        forward_valid = found;
    end

endmodule

`default_nettype wire

//--- design/sq_drain.sv
`default_nettype none

module sq_drain
    import sq_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            wb_ack,
    input  logic            head_valid,
    input  logic            head_executed,
    input  logic            head_committed,
    input  logic [XLEN-1:0] head_addr,
    input  data_word_t      head_data,
    input  mem_size_t       head_size,
    output logic            head_free,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output logic [XLEN-1:0] wb_adr,
    output logic [XLEN-1:0] wb_dat,
    output logic [3:0]      wb_sel
);

    typedef enum logic {
        IDLE,
        WRITE
    } drain_state_t;

    drain_state_t state;
    logic         head_ready;
    data_word_t   placed;
    logic [3:0]   sel;

    // Head may go to the cache
    assign head_ready = head_valid && head_executed && head_committed;

    // Lanes and byte select of the head store
    assign placed = place_lanes(head_size, head_addr[1:0], head_data);

    always_comb begin
        case (head_size)
            BYTE:    sel = 4'b0001 << head_addr[1:0];
            HALF:    sel = head_addr[1] ? 4'b1100 : 4'b0011;
            default: sel = 4'b1111;
        endcase
    end

    // ==========================================================
    // Wishbone classic write master
    // ==========================================================
    assign wb_cyc = state == WRITE;
    assign wb_stb = state == WRITE;
    assign wb_we  = state == WRITE;
    // Cycle ends on the ack edge and the head moves with it
    assign head_free = (state == WRITE) && wb_ack;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (head_ready) state <= WRITE;
                WRITE:   if (wb_ack) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Bus payload held steady until the ack
    always_ff @(posedge clock) begin
        if (state == IDLE && head_ready) begin
            wb_adr <= {head_addr[XLEN-1:2], 2'b00};
            wb_dat <= placed.word;
            wb_sel <= sel;
        end
    end

endmodule

`default_nettype wire

//--- design/store_queue_top.sv
`default_nettype none

module store_queue_top
    import sq_pkg::*;
#(
    parameter  int SQ_DEPTH = DEFAULT_SQ_DEPTH,
    localparam int IDX_W    = $clog2(SQ_DEPTH)
) (
    input  logic             clock,
    input  logic             reset,
    // Dispatch
    input  logic             dispatch_valid,
    input  mem_size_t        dispatch_size,
    output logic             dispatch_ready,
    output logic [IDX_W-1:0] alloc_idx,
    // Execute
    input  logic             exec_valid,
    input  logic [IDX_W-1:0] exec_idx,
    input  logic [XLEN-1:0]  exec_addr,
    input  logic [XLEN-1:0]  exec_data,
    // Retire and recovery
    input  logic             retire,
    input  logic             mispredict,
    output logic             unexecuted_store,
    // Load lookup
    input  logic             load_valid,
    input  logic [XLEN-1:0]  load_addr,
    input  logic [IDX_W-1:0] load_tail,
    output logic             forward_valid,
    output data_word_t       forward_data,
    // Data cache over Wishbone
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic [XLEN-1:0]  wb_adr,
    output logic [XLEN-1:0]  wb_dat,
    output logic [3:0]       wb_sel,
    input  logic             wb_ack
);

    // ==========================================================
    // Internal wires
    // ==========================================================
    logic                write_en;
    logic                flush;
    logic                head_free;
    logic                committed_nonempty;
    logic [IDX_W-1:0]    head_idx;
    logic [IDX_W-1:0]    commit_idx;
    logic [IDX_W-1:0]    tail_idx;
    logic [SQ_DEPTH-1:0] entry_valid;
    logic [XLEN-1:0]     entry_addr [SQ_DEPTH];
    data_word_t          entry_data [SQ_DEPTH];
    mem_size_t           entry_size [SQ_DEPTH];
    logic                head_valid;
    logic                head_executed;
    logic [XLEN-1:0]     head_addr;
    data_word_t          head_data;
    mem_size_t           head_size;

    sq_pointers #(.SQ_DEPTH(SQ_DEPTH)) u_pointers (
        .clock              (clock),
        .reset              (reset),
        .dispatch_valid     (dispatch_valid),
        .retire             (retire),
        .mispredict         (mispredict),
        .head_free          (head_free),
        .dispatch_ready     (dispatch_ready),
        .write_en           (write_en),
        .flush              (flush),
        .committed_nonempty (committed_nonempty),
        .head_idx           (head_idx),
        .commit_idx         (commit_idx),
        .tail_idx           (tail_idx),
        .alloc_idx          (alloc_idx)
    );

    // Executed bits reach the drain through the head fields only
    sq_entry_array #(.SQ_DEPTH(SQ_DEPTH)) u_entries (
        .clock              (clock),
        .reset              (reset),
        .write_en           (write_en),
        .dispatch_size      (dispatch_size),
        .tail_idx           (tail_idx),
        .exec_valid         (exec_valid),
        .exec_idx           (exec_idx),
        .exec_addr          (exec_addr),
        .exec_data          (exec_data),
        .head_free          (head_free),
        .head_idx           (head_idx),
        .flush              (flush),
        .commit_idx         (commit_idx),
        .committed_nonempty (committed_nonempty),
        .entry_valid        (entry_valid),
        .entry_executed     (),
        .entry_addr         (entry_addr),
        .entry_data         (entry_data),
        .entry_size         (entry_size),
        .head_valid         (head_valid),
        .head_executed      (head_executed),
        .head_addr          (head_addr),
        .head_data          (head_data),
        .head_size          (head_size),
        .unexecuted_store   (unexecuted_store)
    );

    sq_forward #(.SQ_DEPTH(SQ_DEPTH)) u_forward (
        .load_valid    (load_valid),
        .load_addr     (load_addr),
        .load_tail     (load_tail),
        .head_idx      (head_idx),
        .entry_valid   (entry_valid),
        .entry_addr    (entry_addr),
        .entry_data    (entry_data),
        .entry_size    (entry_size),
        .forward_valid (forward_valid),
        .forward_data  (forward_data)
    );

    // Any committed entry sits at the head since commit runs in order
    sq_drain u_drain (
        .clock          (clock),
        .reset          (reset),
        .wb_ack         (wb_ack),
        .head_valid     (head_valid),
        .head_executed  (head_executed),
        .head_committed (committed_nonempty),
        .head_addr      (head_addr),
        .head_data      (head_data),
        .head_size      (head_size),
        .head_free      (head_free),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat         (wb_dat),
        .wb_sel         (wb_sel)
    );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    // 4 ns period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Active low for the first two cycles
    initial begin
        reset = 1'b0;
        repeat (2) @(posedge clock);
        #1 reset = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/store_queue_checker.sv
`default_nettype none

module store_queue_checker #(
    parameter int SQ_DEPTH = 8
) (
    input wire logic                clock,
    input wire logic                reset,
    input wire logic                wb_cyc,
    input wire logic                wb_stb,
    input wire logic                wb_ack,
    input wire logic [31:0]         wb_adr,
    input wire logic [31:0]         wb_dat,
    input wire logic [3:0]          wb_sel,
    input wire logic                dispatch_ready,
    input wire logic [SQ_DEPTH-1:0] entry_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // ==========================================================
    // Wishbone classic rules
    // ==========================================================
    stb_needs_cyc: assert property (@(posedge clock) disable iff (!reset)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // Payload held until the slave answers
    payload_steady: assert property (@(posedge clock) disable iff (!reset)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat) && $stable(wb_sel))
        else $error("Wishbone payload changed before ack");

    // Every slot valid means a full queue
    full_blocks_dispatch: assert property (@(posedge clock) disable iff (!reset)
        &entry_valid |-> !dispatch_ready)
        else $error("dispatch_ready high while the queue is full");

endmodule

bind store_queue_top store_queue_checker #(.SQ_DEPTH(SQ_DEPTH)) u_checker (
    .clock          (clock),
    .reset          (reset),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_ack         (wb_ack),
    .wb_adr         (wb_adr),
    .wb_dat         (wb_dat),
    .wb_sel         (wb_sel),
    .dispatch_ready (dispatch_ready),
    .entry_valid    (entry_valid)
);

`default_nettype wire

//--- test/store_queue_tb.sv
`default_nettype none

module store_queue_tb
    import sq_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 8;
    localparam int IDX_W = 3;
    // Five short phases of well under 200 cycles each
    localparam int MAX_CYCLES = 1000;

    logic clock, reset;
    logic dispatch_valid, dispatch_ready, exec_valid, retire, mispredict;
    mem_size_t dispatch_size;
    logic [IDX_W-1:0] alloc_idx, exec_idx, load_tail;
    logic [31:0] exec_addr, exec_data, load_addr, wb_adr, wb_dat;
    logic unexecuted_store, load_valid, forward_valid;
    data_word_t forward_data;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [3:0] wb_sel;

    // Reference queue
    mem_size_t m_size [DEPTH];
    logic [31:0] m_addr [DEPTH];
    logic [31:0] m_data [DEPTH];
    int m_head, m_commit, m_tail;
    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    logic [3:0] exp_sel [$];
    int writes_expected, writes_done;

    tb_clock_gen u_clock (.clock(clock), .reset(reset));

    store_queue_top #(.SQ_DEPTH(DEPTH)) DUT (.*);

    task automatic report_error(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    // Raw data moved to the lanes it covers in memory
    function automatic logic [31:0] lane_data(mem_size_t s, logic [31:0] a, logic [31:0] d);
        case (s)
            BYTE:    return (d & 32'hff) << (8 * a[1:0]);
            HALF:    return (d & 32'hffff) << (16 * a[1]);
            default: return d;
        endcase
    endfunction

    function automatic logic [3:0] lane_sel(mem_size_t s, logic [31:0] a);
        case (s)
            BYTE:    return 4'b0001 << a[1:0];
            HALF:    return 4'b0011 << (2 * a[1]);
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] aligned_addr(mem_size_t s, logic [31:0] a);
        case (s)
            BYTE:    return a;
            HALF:    return a & ~32'h1;
            default: return a & ~32'h3;
        endcase
    endfunction

    // Youngest store older than ltail that covers the load byte
    function automatic logic expect_forward(input logic [31:0] a, input int ltail,
                                            output logic [31:0] d);
        int n;
        int idx;
        logic hit;
        n = (ltail - m_head) & (DEPTH - 1);
        d = '0;
        for (int s = 0; s < n; s++) begin
            idx = (ltail - 1 - s) & (DEPTH - 1);
            case (m_size[idx])
                BYTE:    hit = m_addr[idx] == a;
                HALF:    hit = (m_addr[idx] >> 1) == (a >> 1);
                default: hit = (m_addr[idx] >> 2) == (a >> 2);
            endcase
            if (hit) begin
                d = lane_data(m_size[idx], m_addr[idx], m_data[idx]);
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic dispatch(input mem_size_t s);
        while (!dispatch_ready) step();
        assert (alloc_idx == IDX_W'(m_tail)) else report_error("alloc_idx not consecutive");
        dispatch_valid = 1'b1;
        dispatch_size = s;
        m_size[m_tail] = s;
        step();
        dispatch_valid = 1'b0;
        m_tail = (m_tail + 1) % DEPTH;
    endtask

    task automatic execute(input int idx, input logic [31:0] a, input logic [31:0] d);
        exec_valid = 1'b1;
        exec_idx = IDX_W'(idx);
        exec_addr = aligned_addr(m_size[idx], a);
        exec_data = d;
        m_addr[idx] = exec_addr;
        m_data[idx] = d;
        step();
        exec_valid = 1'b0;
    endtask

    task automatic retire_one();
        exp_adr.push_back(m_addr[m_commit] & ~32'h3);
        exp_dat.push_back(lane_data(m_size[m_commit], m_addr[m_commit], m_data[m_commit]));
        exp_sel.push_back(lane_sel(m_size[m_commit], m_addr[m_commit]));
        writes_expected++;
        retire = 1'b1;
        step();
        retire = 1'b0;
        m_commit = (m_commit + 1) % DEPTH;
    endtask

    // One lookup per cycle, checked while the inputs are stable
    task automatic check_load(input logic [31:0] a, input int ltail);
        logic [31:0] d;
        logic v;
        v = expect_forward(a, ltail, d);
        load_valid = 1'b1;
        load_addr = a;
        load_tail = IDX_W'(ltail);
        #1;
        assert (forward_valid == v) else report_error("forward_valid mismatch");
        assert (!v || forward_data.word == d) else report_error("forward_data mismatch");
        load_valid = 1'b0;
        step();
    endtask

    // ==========================================================
    // Wishbone slave with random ack delay
    // ==========================================================
    initial begin
        wb_ack = 1'b0;
        forever begin
            step();
            if (wb_stb) begin
                repeat ($urandom_range(0, 3)) step();
                assert (wb_cyc && wb_we && exp_adr.size() > 0)
                    else report_error("unexpected Wishbone write");
                assert (wb_adr == exp_adr[0]) else report_error("wb_adr mismatch");
                assert (wb_dat == exp_dat[0]) else report_error("wb_dat mismatch");
                assert (wb_sel == exp_sel[0]) else report_error("wb_sel mismatch");
                void'(exp_adr.pop_front());
                void'(exp_dat.pop_front());
                void'(exp_sel.pop_front());
                wb_ack = 1'b1;
                step();
                wb_ack = 1'b0;
                m_head = (m_head + 1) % DEPTH;
                writes_done++;
            end
        end
    end

    // Watchdog
    initial begin
        repeat (MAX_CYCLES) @(posedge clock);
        $display("Run stopped after %0d cycles without finishing", MAX_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    task automatic wait_drain();
        while (writes_done < writes_expected) step();
    endtask

    initial begin
        void'($urandom(95));
        {dispatch_valid, exec_valid, retire, mispredict, load_valid} = '0;
        dispatch_size = BYTE;
        {exec_idx, load_tail} = '0;
        {exec_addr, exec_data, load_addr} = '0;
        {m_head, m_commit, m_tail, writes_expected, writes_done} = '0;
        @(posedge reset);
        step();
        // After reset
        assert (dispatch_ready && !wb_cyc && !unexecuted_store && alloc_idx == 0)
            else report_error("outputs wrong after reset");
        // Fill the queue
        for (int i = 0; i < DEPTH; i++) dispatch(mem_size_t'($urandom_range(0, 2)));
        assert (!dispatch_ready && unexecuted_store) else report_error("full queue not seen");
        for (int i = 0; i < DEPTH; i++) begin
            assert (unexecuted_store) else report_error("unexecuted_store fell early");
            execute(i, $urandom, $urandom);
        end
        assert (!unexecuted_store) else report_error("unexecuted_store stuck high");
        // Drain in order
        for (int i = 0; i < DEPTH; i++) retire_one();
        wait_drain();
        step();
        assert (dispatch_ready) else report_error("dispatch_ready did not return");
        // Forwarding over overlapping stores
        dispatch(WORD);
        dispatch(HALF);
        dispatch(BYTE);
        dispatch(WORD);
        execute(0, 32'h100, $urandom);
        execute(1, 32'h102, $urandom);
        execute(2, 32'h101, $urandom);
        execute(3, 32'h200, $urandom);
        for (int t = 0; t <= 4; t++) begin
            check_load(32'h100, t);
            check_load(32'h101, t);
            check_load(32'h103, t);
            check_load(32'h202, t);
            check_load(32'h300, t);
        end
        for (int i = 0; i < 4; i++) retire_one();
        wait_drain();
        // Mispredict after two retires
        for (int i = 0; i < 5; i++) dispatch(mem_size_t'($urandom_range(0, 2)));
        // Youngest store stays unexecuted until the flush removes it
        for (int i = 0; i < 4; i++) execute((m_commit + i) % DEPTH, $urandom, $urandom);
        retire_one();
        retire_one();
        mispredict = 1'b1;
        step();
        mispredict = 1'b0;
        m_tail = m_commit;
        assert (alloc_idx == IDX_W'(m_commit)) else report_error("alloc_idx after flush");
        wait_drain();
        repeat (10) step();
        assert (!unexecuted_store) else report_error("flushed store still in the queue");
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
design/sq_pkg.sv
design/sq_pointers.sv
design/sq_entry_array.sv
design/sq_forward.sv
design/sq_drain.sv
design/store_queue_top.sv
test/tb_clock_gen.sv
test/store_queue_checker.sv
test/store_queue_tb.sv

//--- Makefile
TOP = store_queue_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
